/* Makefile */
TOP = tb_dac_reg_config

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps --top-module $(TOP) -f files.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf obj_dir

/* files.f */
+incdir+test
logic/dac_cfg_pkg.sv
logic/cfg_capture.sv
logic/cfg_sequencer.sv
logic/spi_frame_out.sv
logic/dac_reg_config.sv
test/tb_dac_reg_config.sv

/* logic/cfg_capture.sv */
`timescale 1ns/10ps
`default_nettype none

module cfg_capture (
    input  logic                     clk,
    input  logic                     rst_r2,
    input  logic                     cfg_load,
    input  dac_cfg_pkg::cfg_bank_t   cfg_bank,
    input  dac_cfg_pkg::ftw_cfg_t    ftw_cfg,
    output logic                     hold_r,
    output dac_cfg_pkg::cfg_bank_t   snap_bank,
    output dac_cfg_pkg::ftw_frames_t snap_ftw
);

    logic                     hold_d;
    logic                     capture;
    dac_cfg_pkg::ftw_frames_t ftw_fmt;

    //////////////////////////////////////////////////
    // Restart level and falling edge

    always_ff @(posedge clk) begin
        hold_r <= rst_r2 | cfg_load;  // Reset or load keeps us armed
    end

    always_ff @(posedge clk) begin
        if (rst_r2) begin
            hold_d <= 1'b1;
        end else begin
            hold_d <= hold_r;
        end
    end

    assign capture = !hold_r && hold_d;

    //////////////////////////////////////////////////
    // FTW byte frames

    always_comb begin
        for (int i = 0; i < dac_cfg_pkg::FTW_WORDS; i++) begin
            ftw_fmt[i].rw   = ftw_cfg.rw;
            ftw_fmt[i].addr = dac_cfg_pkg::FTW_BASE_ADDR + 7'(i);
            ftw_fmt[i].data = ftw_cfg.ftw[8*i +: 8];
        end
    end

    // Snapshot stays put until the next capture
    always_ff @(posedge clk) begin
        if (capture) begin
            snap_bank <= cfg_bank;
            snap_ftw  <= ftw_fmt;
        end
    end

    // Frames in flight must not see a new snapshot
    a_snap_stable: assert property (
        @(posedge clk)
        hold_r |=> (snap_bank === $past(snap_bank)) && (snap_ftw === $past(snap_ftw))
    ) else $error("snapshot changed while hold_r high");

endmodule

`default_nettype wire

/* logic/cfg_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module cfg_sequencer (
    input  logic                    clk,
    input  logic                    hold_r,
    output dac_cfg_pkg::frame_sel_t frame_sel,
    output logic                    send
);

    dac_cfg_pkg::step_t     step_r;
    dac_cfg_pkg::step_t     step_nxt;
    dac_cfg_pkg::word_idx_t idx_r;
    dac_cfg_pkg::word_idx_t idx_nxt;
    dac_cfg_pkg::dwell_t    timer_r;
    dac_cfg_pkg::dwell_t    limit;

    // Long hold only after the soft reset frame
    assign limit = (step_r == dac_cfg_pkg::STEP_RST_SET) ? dac_cfg_pkg::HOLD_CYCLES
                                                         : dac_cfg_pkg::GAP_CYCLES;

    //////////////////////////////////////////////////
    // Step order

    always_comb begin
        step_nxt = step_r;
        idx_nxt  = '0;
        case (step_r)
            dac_cfg_pkg::STEP_IDLE:    step_nxt = dac_cfg_pkg::STEP_RST_SET;
            dac_cfg_pkg::STEP_RST_SET: step_nxt = dac_cfg_pkg::STEP_RST_CLR;
            dac_cfg_pkg::STEP_RST_CLR: step_nxt = dac_cfg_pkg::STEP_USER;
            dac_cfg_pkg::STEP_USER: begin
                if (idx_r == dac_cfg_pkg::word_idx_t'(dac_cfg_pkg::USER_WORDS - 1)) begin
                    step_nxt = dac_cfg_pkg::STEP_FTW;
                end else begin
                    idx_nxt = idx_r + 3'd1;
                end
            end
            dac_cfg_pkg::STEP_FTW: begin
                if (idx_r == dac_cfg_pkg::word_idx_t'(dac_cfg_pkg::FTW_WORDS - 1)) begin
                    step_nxt = dac_cfg_pkg::STEP_FTW_UPD;
                end else begin
                    idx_nxt = idx_r + 3'd1;
                end
            end
            dac_cfg_pkg::STEP_FTW_UPD: step_nxt = dac_cfg_pkg::STEP_FTW_CLR;
            dac_cfg_pkg::STEP_FTW_CLR: step_nxt = dac_cfg_pkg::STEP_DONE;
            default:                   step_nxt = dac_cfg_pkg::STEP_DONE;
        endcase
    end

    //////////////////////////////////////////////////
    // State and dwell timer

    always_ff @(posedge clk) begin
        if (hold_r) begin
            step_r  <= dac_cfg_pkg::STEP_IDLE;
            idx_r   <= '0;
            timer_r <= '0;
        end else if (step_r == dac_cfg_pkg::STEP_DONE) begin
            timer_r <= '0;  // Park until next load
        end else if (timer_r < limit) begin
            timer_r <= timer_r + 8'd1;
        end else begin
            timer_r <= '0;
            step_r  <= step_nxt;
            idx_r   <= idx_nxt;
        end
    end

    // One frame per step, on the second cycle
    assign send = (timer_r == 8'd1)
               && (step_r != dac_cfg_pkg::STEP_IDLE)
               && (step_r != dac_cfg_pkg::STEP_DONE);

    assign frame_sel.step = step_r;
    assign frame_sel.idx  = idx_r;

    a_send_pulse: assert property (
        @(posedge clk) disable iff (hold_r)
        send |=> !send
    ) else $error("send held longer than one cycle");

    a_user_idx: assert property (
        @(posedge clk) disable iff (hold_r)
        (step_r == dac_cfg_pkg::STEP_USER)
            |=> (step_r != dac_cfg_pkg::STEP_USER) || (idx_r >= $past(idx_r))
    ) else $error("user index wrapped within the user frames");

    a_ftw_idx: assert property (
        @(posedge clk)
        (step_r == dac_cfg_pkg::STEP_FTW) |-> (idx_r < dac_cfg_pkg::FTW_WORDS)
    ) else $error("FTW index out of range");

endmodule

`default_nettype wire

/* logic/dac_cfg_pkg.sv */
`default_nettype none

package dac_cfg_pkg;

    //////////////////////////////////////////////////
    // SPI frame layout

    typedef logic [6:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;

    typedef struct packed {
        logic      rw;    // 0 = write
        reg_addr_t addr;
        reg_data_t data;
    } spi_frame_t;

    localparam logic RW_WRITE = 1'b0;

    //////////////////////////////////////////////////
    // User bank and FTW

    localparam int USER_WORDS = 8;
    localparam int FTW_WORDS  = 4;  // Bytes per tuning word

    typedef spi_frame_t [USER_WORDS-1:0] cfg_bank_t;

    typedef logic [31:0] ftw_word_t;

    typedef struct packed {
        logic      rw;  // Shared by all four FTW frames
        ftw_word_t ftw;
    } ftw_cfg_t;

    typedef spi_frame_t [FTW_WORDS-1:0] ftw_frames_t;

    //////////////////////////////////////////////////
    // Register map

    localparam reg_addr_t RST_ADDR      = 7'h00;
    localparam reg_data_t RST_SET_DATA  = 8'h20;  // Soft reset bit
    localparam reg_data_t RST_CLR_DATA  = 8'h00;

    localparam reg_addr_t FTW_BASE_ADDR = 7'h30;  // Low byte first

    localparam reg_addr_t FTW_UPD_ADDR  = 7'h36;
    localparam reg_data_t FTW_UPD_DATA  = 8'h01;
    localparam reg_data_t FTW_CLR_DATA  = 8'h00;

    //////////////////////////////////////////////////
    // Dwell timing

    typedef logic [7:0] dwell_t;

    localparam dwell_t GAP_CYCLES  = 8'd15;
    localparam dwell_t HOLD_CYCLES = 8'd63;  // Reset hold after soft reset

    //////////////////////////////////////////////////
    // Sequencer steps

    typedef enum logic [2:0] {
        STEP_IDLE,
        STEP_RST_SET,
        STEP_RST_CLR,
        STEP_USER,
        STEP_FTW,
        STEP_FTW_UPD,
        STEP_FTW_CLR,
        STEP_DONE
    } step_t;

    typedef logic [2:0] word_idx_t;

    typedef struct packed {
        step_t     step;
        word_idx_t idx;
    } frame_sel_t;

    // Reset set/clear, user words, FTW bytes, update set/clear
    localparam int SEQ_FRAMES = 2 + USER_WORDS + FTW_WORDS + 2;

endpackage

`default_nettype wire

/* logic/dac_reg_config.sv */
`timescale 1ns/10ps
`default_nettype none

module dac_reg_config (
    input  logic                    clk,
    input  logic                    rst_r2,
    input  logic                    cfg_load,   // Level, sequence starts on its fall
    input  dac_cfg_pkg::cfg_bank_t  cfg_bank,
    input  dac_cfg_pkg::ftw_cfg_t   ftw_cfg,
    output logic                    spi_start,
    output dac_cfg_pkg::spi_frame_t spi_data
);

    logic                     hold_r;
    dac_cfg_pkg::cfg_bank_t   snap_bank;
    dac_cfg_pkg::ftw_frames_t snap_ftw;
    dac_cfg_pkg::frame_sel_t  frame_sel;
    logic                     send;

    //////////////////////////////////////////////////
    // Capture, sequence, output

    cfg_capture u_cfg_capture (
        .clk       (clk),
        .rst_r2    (rst_r2),
        .cfg_load  (cfg_load),
        .cfg_bank  (cfg_bank),
        .ftw_cfg   (ftw_cfg),
        .hold_r    (hold_r),
        .snap_bank (snap_bank),
        .snap_ftw  (snap_ftw)
    );

    cfg_sequencer u_cfg_sequencer (
        .clk       (clk),
        .hold_r    (hold_r),
        .frame_sel (frame_sel),
        .send      (send)
    );

    spi_frame_out u_spi_frame_out (
        .clk       (clk),
        .hold_r    (hold_r),
        .frame_sel (frame_sel),
        .send      (send),
        .snap_bank (snap_bank),
        .snap_ftw  (snap_ftw),
        .spi_start (spi_start),
        .spi_data  (spi_data)
    );

endmodule

`default_nettype wire

/* logic/spi_frame_out.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_frame_out (
    input  logic                     clk,
    input  logic                     hold_r,
    input  dac_cfg_pkg::frame_sel_t  frame_sel,
    input  logic                     send,
    input  dac_cfg_pkg::cfg_bank_t   snap_bank,
    input  dac_cfg_pkg::ftw_frames_t snap_ftw,
    output logic                     spi_start,
    output dac_cfg_pkg::spi_frame_t  spi_data
);

    dac_cfg_pkg::spi_frame_t frame_mux;

    //////////////////////////////////////////////////
    // Frame select

    always_comb begin
        frame_mux.rw = dac_cfg_pkg::RW_WRITE;
        case (frame_sel.step)
            dac_cfg_pkg::STEP_RST_SET: begin
                frame_mux.addr = dac_cfg_pkg::RST_ADDR;
                frame_mux.data = dac_cfg_pkg::RST_SET_DATA;
            end
            dac_cfg_pkg::STEP_RST_CLR: begin
                frame_mux.addr = dac_cfg_pkg::RST_ADDR;
                frame_mux.data = dac_cfg_pkg::RST_CLR_DATA;
            end
            dac_cfg_pkg::STEP_USER: frame_mux = snap_bank[frame_sel.idx];
            dac_cfg_pkg::STEP_FTW:  frame_mux = snap_ftw[frame_sel.idx[1:0]];
            dac_cfg_pkg::STEP_FTW_UPD: begin
                frame_mux.addr = dac_cfg_pkg::FTW_UPD_ADDR;
                frame_mux.data = dac_cfg_pkg::FTW_UPD_DATA;
            end
            dac_cfg_pkg::STEP_FTW_CLR: begin
                frame_mux.addr = dac_cfg_pkg::FTW_UPD_ADDR;
                frame_mux.data = dac_cfg_pkg::FTW_CLR_DATA;
            end
            default: frame_mux = '0;
        endcase
    end

    // Data holds between strobes
    always_ff @(posedge clk) begin
        if (hold_r || frame_sel.step == dac_cfg_pkg::STEP_DONE) begin
            spi_start <= 1'b0;
            spi_data  <= '0;
        end else if (send) begin
            spi_start <= 1'b1;
            spi_data  <= frame_mux;
        end else begin
            spi_start <= 1'b0;
        end
    end

    a_start_pulse: assert property (
        @(posedge clk)
        spi_start |=> !spi_start
    ) else $error("spi_start held longer than one cycle");

endmodule

`default_nettype wire

/* test/tb_frame_model.svh */
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

//////////////////////////////////////////////////
// Reference model

// Frame expected at sequence position pos
function automatic dac_cfg_pkg::spi_frame_t expected_frame(
    input int                     pos,
    input dac_cfg_pkg::cfg_bank_t bank,
    input dac_cfg_pkg::ftw_cfg_t  ftw
);
    dac_cfg_pkg::spi_frame_t frame;
    dac_cfg_pkg::word_idx_t  widx;
    dac_cfg_pkg::ftw_word_t  shifted;
    int                      byte_no;
    frame = '0;
    if (pos == 0) begin
        frame.data = 8'h20;  // Soft reset set at 00h
    end else if (pos == 1) begin
        frame.data = 8'h00;
    end else if (pos < 2 + dac_cfg_pkg::USER_WORDS) begin
        widx  = dac_cfg_pkg::word_idx_t'(pos - 2);
        frame = bank[widx];
    end else if (pos < 2 + dac_cfg_pkg::USER_WORDS + 4) begin
        byte_no    = pos - 2 - dac_cfg_pkg::USER_WORDS;
        shifted    = ftw.ftw >> (8 * byte_no);  // Low byte first
        frame.rw   = ftw.rw;
        frame.addr = 7'h30 + 7'(byte_no);
        frame.data = shifted[7:0];
    end else begin
        frame.addr = 7'h36;
        frame.data = (pos == 2 + dac_cfg_pkg::USER_WORDS + 4) ? 8'h01 : 8'h00;
    end
    return frame;
endfunction

// Cycles before strobe pos, first one counted from the capture edge
function automatic int expected_gap(input int pos);
    if (pos == 0) begin
        return int'(dac_cfg_pkg::GAP_CYCLES) + 3;
    end else if (pos == 1) begin
        return int'(dac_cfg_pkg::HOLD_CYCLES) + 1;  // Long reset hold
    end
    return int'(dac_cfg_pkg::GAP_CYCLES) + 1;
endfunction

//////////////////////////////////////////////////
// Compare tasks

task automatic check_frame(
    input string                   name,
    input dac_cfg_pkg::spi_frame_t exp,
    input dac_cfg_pkg::spi_frame_t act
);
    if (act !== exp) begin
        $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
        frame_errs++;
    end
endtask

task automatic check_gap(input string name, input int exp, input int act);
    if (act != exp) begin
        $display("FAILED t=%0t %s expected %0d cycles got %0d", $time, name, exp, act);
        gap_errs++;
    end
endtask

task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("FAILED t=%0t %s expected %b got %b", $time, name, exp, act);
        strobe_errs++;
    end
endtask

`endif

/* test/tb_dac_reg_config.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_dac_reg_config;

    localparam int FRAME_WAIT     = dac_cfg_pkg::SEQ_FRAMES * 16 + 64 + 32;
    localparam int TIMEOUT_CYCLES = 5 * FRAME_WAIT;
    localparam int SETTLE_CYCLES  = int'(dac_cfg_pkg::GAP_CYCLES) + 2;
    localparam int IDLE_CYCLES    = 100;

    logic                    clk;
    logic                    rst_r2;
    logic                    cfg_load;
    dac_cfg_pkg::cfg_bank_t  cfg_bank;
    dac_cfg_pkg::ftw_cfg_t   ftw_cfg;
    logic                    spi_start;
    dac_cfg_pkg::spi_frame_t spi_data;

    // Values the DUT should hold in its snapshot
    dac_cfg_pkg::cfg_bank_t  exp_bank;
    dac_cfg_pkg::ftw_cfg_t   exp_ftw;

    integer seed;
    int     cycle_count = 0;
    int     pos         = 0;  // Strobes seen in the current sequence
    int     start_cyc   = 0;
    int     last_cyc    = 0;
    int     hold_cnt    = 0;
    logic   start_prev  = 1'b0;
    int     frame_errs  = 0;
    int     gap_errs    = 0;
    int     strobe_errs = 0;
    int     wait_errs   = 0;

    `include "tb_frame_model.svh"

    dac_reg_config u_dac_reg_config (
        .clk       (clk),
        .rst_r2    (rst_r2),
        .cfg_load  (cfg_load),
        .cfg_bank  (cfg_bank),
        .ftw_cfg   (ftw_cfg),
        .spi_start (spi_start),
        .spi_data  (spi_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Run stopped after %0d cycles without finishing", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // Frame monitor, sampled on the falling edge

    always @(negedge clk) begin : monitor
        logic rise;
        rise = (spi_start === 1'b1) && !start_prev;
        if (spi_start === 1'b1 && start_prev) begin
            $display("spi_start stayed high for more than one cycle at t=%0t", $time);
            strobe_errs++;
        end
        if (rst_r2 || cfg_load) begin
            pos = 0;
            if (hold_cnt < 3) begin
                hold_cnt++;
            end else begin  // Hold has reached the output stage
                check_level("spi_start", 1'b0, spi_start);
                check_frame("spi_data", '0, spi_data);
            end
        end else begin
            if (hold_cnt != 0) begin
                start_cyc = cycle_count + 1;  // Next rising edge captures
                hold_cnt  = 0;
            end
            if (rise && pos >= dac_cfg_pkg::SEQ_FRAMES) begin
                $display("Extra strobe after the last frame at t=%0t", $time);
                strobe_errs++;
            end else if (rise) begin
                check_frame("spi_data", expected_frame(pos, exp_bank, exp_ftw), spi_data);
                check_gap("spi_start interval", expected_gap(pos),
                          (pos == 0) ? cycle_count - start_cyc : cycle_count - last_cyc);
                last_cyc = cycle_count;
                pos++;
            end else if (pos == dac_cfg_pkg::SEQ_FRAMES
                         && cycle_count - last_cyc > int'(dac_cfg_pkg::GAP_CYCLES)) begin
                check_frame("spi_data", '0, spi_data);  // Parked in done
            end
        end
        start_prev = (spi_start === 1'b1);
    end

    //////////////////////////////////////////////////
    // Stimulus

    task automatic randomize_inputs();
        logic [31:0] rnd;
        for (int i = 0; i < dac_cfg_pkg::USER_WORDS; i++) begin
            rnd         = $random(seed);
            cfg_bank[i] = rnd[15:0];
        end
        rnd         = $random(seed);
        ftw_cfg.ftw = rnd;
        rnd         = $random(seed);
        ftw_cfg.rw  = rnd[0];
    endtask

    // New values go in while load is high, and move again as it falls
    task automatic pulse_load(input int cycles);
        @(posedge clk);
        #2;
        cfg_load = 1'b1;
        randomize_inputs();
        repeat (cycles) @(posedge clk);
        #2;
        randomize_inputs();
        exp_bank = cfg_bank;
        exp_ftw  = ftw_cfg;
        cfg_load = 1'b0;
    endtask

    task automatic wait_frames(input int count);
        int waited;
        waited = 0;
        while (pos < count && waited < FRAME_WAIT) begin
            @(posedge clk);
            waited++;
        end
        if (pos < count) begin
            $display("Only %0d of %0d frames appeared at t=%0t", pos, count, $time);
            wait_errs++;
        end
    endtask

    initial begin : stimulus
        seed     = 32'h54281d85;
        rst_r2   = 1'b1;
        cfg_load = 1'b0;
        randomize_inputs();
        exp_bank = cfg_bank;
        exp_ftw  = ftw_cfg;
        repeat (10) @(posedge clk);
        #2;
        rst_r2 = 1'b0;

        // Sequence out of reset, then a quiet stretch
        wait_frames(dac_cfg_pkg::SEQ_FRAMES);
        repeat (SETTLE_CYCLES + IDLE_CYCLES) @(posedge clk);

        // Inputs move after the snapshot
        pulse_load(4);
        wait_frames(3);
        @(posedge clk);
        #2;
        randomize_inputs();
        wait_frames(dac_cfg_pkg::SEQ_FRAMES);
        repeat (SETTLE_CYCLES) @(posedge clk);

        // Reload in the middle of the user frames
        pulse_load(4);
        wait_frames(6);
        pulse_load(20);
        wait_frames(dac_cfg_pkg::SEQ_FRAMES);
        repeat (SETTLE_CYCLES + IDLE_CYCLES) @(posedge clk);

        $display("Errors: frame %0d, interval %0d, strobe %0d, missing %0d",
                 frame_errs, gap_errs, strobe_errs, wait_errs);
        if (frame_errs + gap_errs + strobe_errs + wait_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
